// ==== Bender.yml ====
package:
  name: host_bridge

sources:
  - source/bridge_pkg.sv
  - source/unit_req_if.sv
  - source/command_decoder.sv
  - source/wb_access.sv
  - source/local_responder.sv
  - source/response_merge.sv
  - source/host_bridge_top.sv
  - target: test
    files:
      - sim/tb_host_bridge.sv

// ==== list.f ====
source/bridge_pkg.sv
source/unit_req_if.sv
source/command_decoder.sv
source/wb_access.sv
source/local_responder.sv
source/response_merge.sv
source/host_bridge_top.sv
sim/tb_host_bridge.sv

// ==== sim/tb_host_bridge.sv ====
// host bridge testbench
`timescale 1ns/1ps

module tb_host_bridge import bridge_pkg::*; ();

	localparam int TIMEOUT = 200;
	localparam int DRIVE_DLY = 1;
	localparam int RSP_W = 3 * WORD_W;

	logic              clk;
	logic              rst;
	logic              in_ready_i;
	logic [WORD_W-1:0] in_command_i;
	logic [WORD_W-1:0] in_address_i;
	logic [WORD_W-1:0] in_data_i;
	logic              master_ready_o;
	logic              out_en_o;
	logic [WORD_W-1:0] out_status_o;
	logic [WORD_W-1:0] out_address_o;
	logic [WORD_W-1:0] out_data_o;
	logic [WORD_W-1:0] wb_addr_o;
	logic [WORD_W-1:0] wb_dat_o;
	logic [WORD_W-1:0] wb_dat_i;
	logic              wb_str_o;
	logic              wb_cyc_o;
	logic              wb_we_o;
	logic [SEL_W-1:0]  wb_sel_o;
	logic              wb_ack_i;

	// slave memory and the reference image of it
	logic [WORD_W-1:0] mem [0:255];
	logic [WORD_W-1:0] model_mem [0:255];
	logic [WORD_W-1:0] model_flags;
	logic [RSP_W-1:0]  exp_q [$];
	integer            seed;
	integer            ack_seed;
	int                cycle;
	int                sent_cycle;
	int                rsp_cycle;
	int                error_count;

	host_bridge_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [WORD_W-1:0] fill_word(input int idx);
		logic [7:0] a;
		a = idx[7:0];
		return {a, ~a, a ^ 8'h5a, 8'hc3 + a};
	endfunction

	function automatic logic [WORD_W-1:0] merge_lanes(input logic [WORD_W-1:0] old_w,
			input logic [WORD_W-1:0] new_w, input logic [SEL_W-1:0] sel);
		logic [WORD_W-1:0] res;
		res = old_w;
		for (int b = 0; b < SEL_W; b++) begin
			if (sel[b]) begin
				res[b*8 +: 8] = new_w[b*8 +: 8];
			end
		end
		return res;
	endfunction

	// beat marks one data word inside a stream
	function automatic logic [RSP_W-1:0] expected_response(input logic [WORD_W-1:0] cmd,
			input logic [WORD_W-1:0] addr, input logic [WORD_W-1:0] data, input logic beat);
		logic [WORD_W-1:0] rdata;
		rdata = data;
		if (beat) begin
			if (cmd == CMD_WSTREAM_C || cmd == CMD_WSTREAM) begin
				model_mem[addr[7:0]] = merge_lanes(model_mem[addr[7:0]], data, model_flags[SEL_W-1:0]);
			end else begin
				rdata = model_mem[addr[7:0]];
			end
			return {~cmd, addr, rdata};
		end
		case (cmd)
			CMD_PING: return {~cmd, {WORD_W{1'b0}}, PING_SIGNATURE};
			CMD_WRITE: begin
				model_mem[addr[7:0]] = merge_lanes(model_mem[addr[7:0]], data, model_flags[SEL_W-1:0]);
				return {~cmd, addr, data};
			end
			CMD_READ: return {~cmd, addr, model_mem[addr[7:0]]};
			CMD_RW_FLAGS: begin
				rdata = model_flags;
				if (addr != '0) begin
					model_flags = data;
				end
				return {~cmd, addr, rdata};
			end
			// stream header carries the count
			default: return {~cmd, addr, data};
		endcase
	endfunction

	// wishbone slave with a random ack delay
	initial begin : slave
		int delay;
		wb_ack_i = 1'b0;
		wb_dat_i = '0;
		for (int i = 0; i < 256; i++) begin
			mem[i] = fill_word(i);
		end
		forever begin
			@(posedge clk);
			#DRIVE_DLY;
			if (wb_cyc_o && wb_str_o) begin
				delay = $random(ack_seed) & 3;
				repeat (delay) begin
					@(posedge clk);
					#DRIVE_DLY;
				end
				if (wb_we_o) begin
					mem[wb_addr_o[7:0]] = merge_lanes(mem[wb_addr_o[7:0]], wb_dat_o, wb_sel_o);
				end else begin
					wb_dat_i = mem[wb_addr_o[7:0]];
				end
				wb_ack_i = 1'b1;
				@(posedge clk);
				#DRIVE_DLY;
				wb_ack_i = 1'b0;
			end
		end
	end

	always @(negedge clk) begin : compare_responses
		logic [RSP_W-1:0] got;
		logic [RSP_W-1:0] want;
		if (!rst && out_en_o) begin
			rsp_cycle = cycle;
			got = {out_status_o, out_address_o, out_data_o};
			assert (exp_q.size() != 0) else begin
				error_count++;
				$display("Unexpected response at %0t with no response pending", $time);
				$display("Test failed");
				$fatal(1, "unexpected response");
			end
			want = exp_q.pop_front();
			assert (got == want) else begin
				error_count++;
				$display("Mismatch at %0t: got %h %h %h, expected %h %h %h", $time,
					got[RSP_W-1 -: WORD_W], got[2*WORD_W-1 -: WORD_W], got[WORD_W-1:0],
					want[RSP_W-1 -: WORD_W], want[2*WORD_W-1 -: WORD_W], want[WORD_W-1:0]);
				$display("Test failed");
				$fatal(1, "response mismatch");
			end
		end
	end

	task automatic wait_ready();
		int waited;
		waited = 0;
		while (!master_ready_o) begin
			if (waited == TIMEOUT) begin
				$display("Timed out at %0t waiting for master_ready_o", $time);
				$display("Test failed");
				$fatal(1, "ready timeout");
			end
			@(posedge clk);
			#DRIVE_DLY;
			waited++;
		end
	endtask

	task automatic wait_responses();
		int waited;
		waited = 0;
		while (exp_q.size() != 0) begin
			if (waited == TIMEOUT) begin
				$display("Timed out at %0t with %0d responses missing", $time, exp_q.size());
				$display("Test failed");
				$fatal(1, "response timeout");
			end
			@(posedge clk);
			#DRIVE_DLY;
			waited++;
		end
	endtask

	task automatic send_command(input logic [WORD_W-1:0] cmd, input logic [WORD_W-1:0] addr,
			input logic [WORD_W-1:0] data);
		wait_ready();
		in_ready_i = 1'b1;
		in_command_i = cmd;
		in_address_i = addr;
		in_data_i = data;
		sent_cycle = cycle;
		@(posedge clk);
		#DRIVE_DLY;
		in_ready_i = 1'b0;
	endtask

	// single command with one response
	task automatic run_single(input logic [WORD_W-1:0] cmd, input logic [WORD_W-1:0] addr,
			input logic [WORD_W-1:0] data);
		exp_q.push_back(expected_response(cmd, addr, data, 1'b0));
		send_command(cmd, addr, data);
	endtask

	task automatic write_stream(input logic [WORD_W-1:0] cmd, input logic [WORD_W-1:0] addr,
			input int n);
		logic [WORD_W-1:0] a;
		logic [WORD_W-1:0] d;
		logic [RSP_W-1:0]  unused;
		a = addr;
		run_single(cmd, addr, n);
		for (int i = 0; i < n; i++) begin
			d = $random(seed);
			// stream writes are silent
			unused = expected_response(cmd, a, d, 1'b1);
			send_command(cmd, '0, d);
			if (cmd == CMD_WSTREAM_C) begin
				a = a + 1;
			end
		end
		wait_ready();
	endtask

	task automatic read_stream(input logic [WORD_W-1:0] cmd, input logic [WORD_W-1:0] addr,
			input int n);
		logic [WORD_W-1:0] a;
		a = addr;
		exp_q.push_back(expected_response(cmd, addr, n, 1'b0));
		for (int i = 0; i < n; i++) begin
			exp_q.push_back(expected_response(cmd, a, '0, 1'b1));
			if (cmd == CMD_RSTREAM_C) begin
				a = a + 1;
			end
		end
		send_command(cmd, addr, n);
		wait_responses();
	endtask

	initial begin : stimulus
		logic [WORD_W-1:0] addrs [8];
		seed = 46775;
		ack_seed = 46775;
		cycle = 0;
		error_count = 0;
		rst = 1'b1;
		in_ready_i = 1'b0;
		in_command_i = '0;
		in_address_i = '0;
		in_data_i = '0;
		model_flags = FLAGS_RESET;
		for (int i = 0; i < 256; i++) begin
			model_mem[i] = fill_word(i);
		end
		repeat (10) @(posedge clk);
		#DRIVE_DLY;
		rst = 1'b0;

		// ping latency is fixed
		run_single(CMD_PING, 32'h0000_1234, 32'h5555_aaaa);
		wait_responses();
		assert (rsp_cycle - sent_cycle == 3) else begin
			error_count++;
			$display("Mismatch at %0t: ping latency %0d cycles, expected 3", $time,
				rsp_cycle - sent_cycle);
			$display("Test failed");
			$fatal(1, "ping latency");
		end

		// random singles under random ack delay
		for (int i = 0; i < 8; i++) begin
			addrs[i] = $random(seed) & 8'hff;
			run_single(CMD_WRITE, addrs[i], $random(seed));
		end
		for (int i = 0; i < 8; i++) begin
			run_single(CMD_READ, addrs[i], '0);
		end
		wait_responses();

		write_stream(CMD_WSTREAM_C, 32'h40, 5);
		write_stream(CMD_WSTREAM, 32'h80, 3);
		wait_responses();
		read_stream(CMD_RSTREAM_C, 32'h40, 5);
		read_stream(CMD_RSTREAM, 32'h80, 3);

		// narrow the lane mask and watch read-back
		run_single(CMD_RW_FLAGS, 32'h1, 32'h3);
		run_single(CMD_WRITE, 32'h10, 32'hdead_beef);
		run_single(CMD_READ, 32'h10, '0);
		run_single(CMD_RW_FLAGS, 32'h0, 32'hff);
		run_single(CMD_RW_FLAGS, 32'h1, FLAGS_RESET);
		run_single(CMD_WRITE, 32'h11, 32'h1234_5678);
		run_single(CMD_READ, 32'h11, '0);
		wait_responses();

		// empty streams give the header only
		read_stream(CMD_RSTREAM_C, 32'h20, 0);
		write_stream(CMD_WSTREAM, 32'h20, 0);
		wait_responses();
		wait_ready();

		if (error_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== source/bridge_pkg.sv ====
// host bridge shared definitions
package bridge_pkg;

	// command, address, data and status words
	localparam int WORD_W = 32;

	// wishbone byte lanes
	localparam int SEL_W = 4;

	// data word answered on a ping
	localparam logic [WORD_W-1:0] PING_SIGNATURE = 32'h0000_1EAF;

	// all byte lanes enabled out of reset
	localparam logic [WORD_W-1:0] FLAGS_RESET = 32'h0000_000F;

	// host opcodes travel as a full word
	typedef enum logic [WORD_W-1:0] {
		CMD_PING      = 32'd0,
		CMD_WRITE     = 32'd1,
		CMD_READ      = 32'd2,
		CMD_WSTREAM_C = 32'd3,
		CMD_WSTREAM   = 32'd4,
		CMD_RSTREAM_C = 32'd5,
		CMD_RSTREAM   = 32'd6,
		CMD_RW_FLAGS  = 32'd7
	} cmd_e;

	typedef enum logic [1:0] {
		IDLE,
		WAIT_UNIT,
		STREAM_WRITE,
		STREAM_READ
	} dec_state_e;

	// work items handed to the bus unit or the local unit
	typedef enum logic [2:0] {
		OP_WB_WRITE,
		OP_WB_READ,
		OP_PING,
		OP_FLAGS,
		OP_HEADER
	} op_e;

endpackage

// ==== source/command_decoder.sv ====
// host command decoder
`timescale 1ns/1ps

module command_decoder import bridge_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_ready_i,
	input  logic [WORD_W-1:0] in_command_i,
	input  logic [WORD_W-1:0] in_address_i,
	input  logic [WORD_W-1:0] in_data_i,
	output logic              master_ready_o,
	unit_req_if.decoder       wb_port,
	unit_req_if.decoder       loc_port
);

	dec_state_e        state;
	logic [WORD_W-1:0] cmd_q;
	logic [WORD_W-1:0] cur_addr_q;
	logic [WORD_W-1:0] count_q;
	op_e               op_q;
	logic [WORD_W-1:0] req_addr_q;
	logic [WORD_W-1:0] req_data_q;
	logic              wb_req_q;
	logic              loc_req_q;
	logic              wb_pend;
	logic              loc_pend;
	logic              accept;
	logic              any_done;
	logic              wstream;
	logic              rstream;
	logic              consec;
	logic              in_stream;
	logic              issue_wb;
	logic              issue_loc;
	op_e               issue_op;
	logic [WORD_W-1:0] issue_addr;

	assign accept = in_ready_i && master_ready_o;
	assign any_done = wb_port.done || loc_port.done;
	assign wstream = (cmd_q == CMD_WSTREAM_C) || (cmd_q == CMD_WSTREAM);
	assign rstream = (cmd_q == CMD_RSTREAM_C) || (cmd_q == CMD_RSTREAM);
	assign consec = (cmd_q == CMD_WSTREAM_C) || (cmd_q == CMD_RSTREAM_C);
	assign in_stream = (state == STREAM_WRITE) || (state == STREAM_READ);

	// pick the unit and operation for this cycle
	always_comb begin
		issue_wb = 1'b0;
		issue_loc = 1'b0;
		issue_op = OP_PING;
		issue_addr = cur_addr_q;
		case (state)
			IDLE: begin
				issue_addr = in_address_i;
				if (accept) begin
					case (in_command_i)
						CMD_PING: begin
							issue_loc = 1'b1;
							issue_op = OP_PING;
						end
						CMD_WRITE: begin
							issue_wb = 1'b1;
							issue_op = OP_WB_WRITE;
						end
						CMD_READ: begin
							issue_wb = 1'b1;
							issue_op = OP_WB_READ;
						end
						CMD_RW_FLAGS: begin
							issue_loc = 1'b1;
							issue_op = OP_FLAGS;
						end
						CMD_WSTREAM_C, CMD_WSTREAM, CMD_RSTREAM_C, CMD_RSTREAM: begin
							issue_loc = 1'b1;
							issue_op = OP_HEADER;
						end
						// unknown opcodes are dropped
						default: ;
					endcase
				end
			end
			STREAM_WRITE: begin
				issue_wb = accept;
				issue_op = OP_WB_WRITE;
			end
			STREAM_READ: begin
				issue_wb = 1'b1;
				issue_op = OP_WB_READ;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			master_ready_o <= 1'b1;
			wb_req_q <= 1'b0;
			loc_req_q <= 1'b0;
			count_q <= '0;
			wb_pend <= 1'b0;
			loc_pend <= 1'b0;
		end else begin
			wb_req_q <= issue_wb;
			loc_req_q <= issue_loc;
			if (issue_wb || issue_loc) begin
				master_ready_o <= 1'b0;
				state <= WAIT_UNIT;
			end
			if (state == IDLE && accept) begin
				count_q <= in_data_i;
			end else if (in_stream && issue_wb) begin
				count_q <= count_q - WORD_W'(1);
			end
			// next step once the unit has answered
			if (state == WAIT_UNIT && any_done) begin
				if (count_q != '0 && wstream) begin
					state <= STREAM_WRITE;
					master_ready_o <= 1'b1;
				end else if (count_q != '0 && rstream) begin
					state <= STREAM_READ;
				end else begin
					state <= IDLE;
					master_ready_o <= 1'b1;
				end
			end
			if (wb_req_q) begin
				wb_pend <= 1'b1;
			end else if (wb_port.done) begin
				wb_pend <= 1'b0;
			end
			if (loc_req_q) begin
				loc_pend <= 1'b1;
			end else if (loc_port.done) begin
				loc_pend <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && accept) begin
			cmd_q <= in_command_i;
			cur_addr_q <= in_address_i;
		end else if (in_stream && issue_wb && consec) begin
			cur_addr_q <= cur_addr_q + WORD_W'(1);
		end
		if (issue_wb || issue_loc) begin
			op_q <= issue_op;
			req_addr_q <= issue_addr;
			req_data_q <= in_data_i;
		end
	end

	assign wb_port.req = wb_req_q;
	assign wb_port.op = op_q;
	assign wb_port.cmd = cmd_q;
	assign wb_port.addr = req_addr_q;
	assign wb_port.data = req_data_q;
	assign loc_port.req = loc_req_q;
	assign loc_port.op = op_q;
	assign loc_port.cmd = cmd_q;
	assign loc_port.addr = req_addr_q;
	assign loc_port.data = req_data_q;

	// one request in flight per unit
	assert property (@(posedge clk) disable iff (rst) wb_req_q |-> !wb_pend);
	assert property (@(posedge clk) disable iff (rst) loc_req_q |-> !loc_pend);

endmodule

// ==== source/host_bridge_top.sv ====
// host command bridge
`timescale 1ns/1ps

module host_bridge_top import bridge_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	input  logic              in_ready_i,
	input  logic [WORD_W-1:0] in_command_i,
	input  logic [WORD_W-1:0] in_address_i,
	input  logic [WORD_W-1:0] in_data_i,
	output logic              master_ready_o,
	output logic              out_en_o,
	output logic [WORD_W-1:0] out_status_o,
	output logic [WORD_W-1:0] out_address_o,
	output logic [WORD_W-1:0] out_data_o,
	output logic [WORD_W-1:0] wb_addr_o,
	output logic [WORD_W-1:0] wb_dat_o,
	input  logic [WORD_W-1:0] wb_dat_i,
	output logic              wb_str_o,
	output logic              wb_cyc_o,
	output logic              wb_we_o,
	output logic [SEL_W-1:0]  wb_sel_o,
	input  logic              wb_ack_i
);

	logic [SEL_W-1:0] flags_sel;

	unit_req_if req_wb ();
	unit_req_if req_loc ();

	command_decoder decoder0 (
		.clk            (clk),
		.rst            (rst),
		.in_ready_i     (in_ready_i),
		.in_command_i   (in_command_i),
		.in_address_i   (in_address_i),
		.in_data_i      (in_data_i),
		.master_ready_o (master_ready_o),
		.wb_port        (req_wb.decoder),
		.loc_port       (req_loc.decoder)
	);

	wb_access wb0 (
		.clk         (clk),
		.rst         (rst),
		.port        (req_wb.unit),
		.flags_sel_i (flags_sel),
		.wb_addr_o   (wb_addr_o),
		.wb_dat_o    (wb_dat_o),
		.wb_dat_i    (wb_dat_i),
		.wb_str_o    (wb_str_o),
		.wb_cyc_o    (wb_cyc_o),
		.wb_we_o     (wb_we_o),
		.wb_sel_o    (wb_sel_o),
		.wb_ack_i    (wb_ack_i)
	);

	local_responder local0 (
		.clk         (clk),
		.rst         (rst),
		.port        (req_loc.unit),
		.flags_sel_o (flags_sel)
	);

	response_merge merge0 (
		.clk           (clk),
		.rst           (rst),
		.wb_port       (req_wb.decoder),
		.loc_port      (req_loc.decoder),
		.out_en_o      (out_en_o),
		.out_status_o  (out_status_o),
		.out_address_o (out_address_o),
		.out_data_o    (out_data_o)
	);

endmodule

// ==== source/local_responder.sv ====
// local register responder
`timescale 1ns/1ps

module local_responder import bridge_pkg::*; (
	input  logic             clk,
	input  logic             rst,
	unit_req_if.unit         port,
	output logic [SEL_W-1:0] flags_sel_o
);

	logic [WORD_W-1:0] flags_q;
	logic [WORD_W-1:0] rsp_status_q;
	logic [WORD_W-1:0] rsp_addr_q;
	logic [WORD_W-1:0] rsp_data_q;
	logic              done_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			flags_q <= FLAGS_RESET;
			done_q <= 1'b0;
		end else begin
			done_q <= port.req;
			// zero address means read only
			if (port.req && port.op == OP_FLAGS && port.addr != '0) begin
				flags_q <= port.data;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (port.req) begin
			rsp_status_q <= ~port.cmd;
			case (port.op)
				OP_PING: begin
					rsp_addr_q <= '0;
					rsp_data_q <= PING_SIGNATURE;
				end
				OP_FLAGS: begin
					rsp_addr_q <= port.addr;
					rsp_data_q <= flags_q;
				end
				// stream header echoes the word count
				default: begin
					rsp_addr_q <= port.addr;
					rsp_data_q <= port.data;
				end
			endcase
		end
	end

	assign port.done = done_q;
	assign port.rsp_status = rsp_status_q;
	assign port.rsp_addr = rsp_addr_q;
	assign port.rsp_data = rsp_data_q;
	assign port.silent = 1'b0;
	assign flags_sel_o = flags_q[SEL_W-1:0];

endmodule

// ==== source/response_merge.sv ====
// response merger
`timescale 1ns/1ps

module response_merge import bridge_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	unit_req_if.decoder       wb_port,
	unit_req_if.decoder       loc_port,
	output logic              out_en_o,
	output logic [WORD_W-1:0] out_status_o,
	output logic [WORD_W-1:0] out_address_o,
	output logic [WORD_W-1:0] out_data_o
);

	logic wb_take;
	logic loc_take;

	// completions that reach the host
	assign wb_take = wb_port.done && !wb_port.silent;
	assign loc_take = loc_port.done && !loc_port.silent;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_en_o <= 1'b0;
		end else begin
			out_en_o <= wb_take || loc_take;
		end
	end

	// words hold until the next strobe
	always_ff @(posedge clk) begin
		if (wb_take) begin
			out_status_o <= wb_port.rsp_status;
			out_address_o <= wb_port.rsp_addr;
			out_data_o <= wb_port.rsp_data;
		end else if (loc_take) begin
			out_status_o <= loc_port.rsp_status;
			out_address_o <= loc_port.rsp_addr;
			out_data_o <= loc_port.rsp_data;
		end
	end

	// decoder keeps a single operation in flight
	assert property (@(posedge clk) disable iff (rst) !(wb_port.done && loc_port.done));

endmodule

// ==== source/unit_req_if.sv ====
// unit request channel
`timescale 1ns/1ps

interface unit_req_if import bridge_pkg::*; ();

	// request side, owned by the decoder
	logic              req;
	op_e               op;
	logic [WORD_W-1:0] cmd;
	logic [WORD_W-1:0] addr;
	logic [WORD_W-1:0] data;

	// completion side, owned by the unit
	logic              done;
	logic [WORD_W-1:0] rsp_status;
	logic [WORD_W-1:0] rsp_addr;
	logic [WORD_W-1:0] rsp_data;
	// completion with no host response
	logic              silent;

	modport decoder (
		output req, op, cmd, addr, data,
		input  done, rsp_status, rsp_addr, rsp_data, silent
	);

	modport unit (
		input  req, op, cmd, addr, data,
		output done, rsp_status, rsp_addr, rsp_data, silent
	);

endinterface

// ==== source/wb_access.sv ====
// wishbone cycle engine
`timescale 1ns/1ps

module wb_access import bridge_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	unit_req_if.unit          port,
	input  logic [SEL_W-1:0]  flags_sel_i,
	output logic [WORD_W-1:0] wb_addr_o,
	output logic [WORD_W-1:0] wb_dat_o,
	input  logic [WORD_W-1:0] wb_dat_i,
	output logic              wb_str_o,
	output logic              wb_cyc_o,
	output logic              wb_we_o,
	output logic [SEL_W-1:0]  wb_sel_o,
	input  logic              wb_ack_i
);

	logic [WORD_W-1:0] cmd_q;
	logic [WORD_W-1:0] rsp_data_q;
	logic              done_q;
	logic              finish;

	// slave acknowledges the open cycle
	assign finish = wb_cyc_o && wb_ack_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_cyc_o <= 1'b0;
			wb_str_o <= 1'b0;
			wb_we_o <= 1'b0;
			done_q <= 1'b0;
		end else begin
			done_q <= finish;
			if (port.req) begin
				wb_cyc_o <= 1'b1;
				wb_str_o <= 1'b1;
				wb_we_o <= (port.op == OP_WB_WRITE);
			end else if (finish) begin
				wb_cyc_o <= 1'b0;
				wb_str_o <= 1'b0;
				wb_we_o <= 1'b0;
			end
		end
	end

	// lanes come from the flags register at request time
	always_ff @(posedge clk) begin
		if (port.req) begin
			wb_addr_o <= port.addr;
			wb_dat_o <= port.data;
			wb_sel_o <= flags_sel_i;
			cmd_q <= port.cmd;
		end
		if (finish) begin
			rsp_data_q <= wb_we_o ? wb_dat_o : wb_dat_i;
		end
	end

	assign port.done = done_q;
	assign port.rsp_status = ~cmd_q;
	assign port.rsp_addr = wb_addr_o;
	assign port.rsp_data = rsp_data_q;
	// stream data writes stay quiet
	assign port.silent = (cmd_q == CMD_WSTREAM_C) || (cmd_q == CMD_WSTREAM);

	assert property (@(posedge clk) disable iff (rst) $rose(wb_str_o) |-> wb_cyc_o);
	// no new request while a bus cycle is still open
	assert property (@(posedge clk) disable iff (rst) port.req |-> !wb_cyc_o);

endmodule
